//--- design/dcache_pkg.sv
//**************************************************************************
// Data cache pipeline definitions
// Shared constants, access opcodes and the structs passed between stages
//**************************************************************************

`default_nettype none

package dcache_pkg;

	parameter int VECTOR_LANES = 16;
	parameter int CACHE_LINE_WORDS = 16;
	parameter int CACHE_LINE_BYTES = 64;
	parameter int CACHE_LINE_OFFSET_BITS = 6;
	parameter int NUM_CREGS = 8;
	parameter int THREAD_BITS = 2;

	typedef logic [31:0] scalar_t;
	typedef scalar_t [VECTOR_LANES - 1:0] vector_t;

	// B and S zero-extend, BX and SX sign-extend
	typedef enum logic [2:0]
	{
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK,
		MEM_CONTROL_REG
	} mem_op_t;

	typedef struct packed
	{
		mem_op_t op;
		logic is_load;
		logic [THREAD_BITS - 1:0] thread_idx;
		scalar_t addr;
		logic [VECTOR_LANES - 1:0] mask;
		vector_t store_value;
	} mem_request_t;

	typedef struct packed
	{
		mem_request_t req;
		logic [31 - CACHE_LINE_OFFSET_BITS:0] line_idx;
		logic [CACHE_LINE_OFFSET_BITS - 3:0] word_offset;
	} tag_stage_t;

	typedef struct packed
	{
		mem_op_t op;
		logic is_load;
		logic [THREAD_BITS - 1:0] thread_idx;
		logic [CACHE_LINE_OFFSET_BITS - 3:0] word_offset;
		logic [1:0] byte_offset;
	} data_stage_t;

	typedef struct packed
	{
		logic [THREAD_BITS - 1:0] thread_idx;
		logic is_vector;
		vector_t value;
	} mem_result_t;

	// Register order (MSB first) to line byte order and back
	function automatic scalar_t byte_swap(input scalar_t value);
		byte_swap = {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

endpackage

`default_nettype wire

//--- design/dcache_tag_stage.sv
//**************************************************************************
// Data cache tag stage
// Registers an incoming request and splits its address into line and word
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_tag_stage
(
	input wire logic clk,
	input wire logic reset,
	input wire logic req_valid,
	input wire dcache_pkg::mem_request_t req,
	output logic ts_valid,
	output dcache_pkg::tag_stage_t ts
);

	localparam int OFFSET_BITS = dcache_pkg::CACHE_LINE_OFFSET_BITS;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ts_valid <= 1'b0;
		else
			ts_valid <= req_valid;
	end

	// Payload only, qualified by ts_valid
	always_ff @(posedge clk)
	begin
		ts.req <= req;
		ts.line_idx <= req.addr[31:OFFSET_BITS];
		ts.word_offset <= req.addr[OFFSET_BITS - 1:2];
	end

endmodule

`default_nettype wire

//--- design/dcache_data_stage.sv
//**************************************************************************
// Data cache data stage
// Drives line memory and control registers, squashes on thread rollback
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_data_stage
#(
	parameter int LINE_IDX_BITS = 2
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic ts_valid,
	input wire dcache_pkg::tag_stage_t ts,
	input wire logic rollback_en,
	input wire logic [dcache_pkg::THREAD_BITS - 1:0] rollback_thread_idx,
	output logic [LINE_IDX_BITS - 1:0] ram_line_idx,
	output logic ram_read_en,
	output logic ram_write_en,
	output logic [dcache_pkg::CACHE_LINE_BYTES * 8 - 1:0] ram_write_data,
	output logic [dcache_pkg::CACHE_LINE_BYTES - 1:0] ram_write_mask,
	output logic creg_read_en,
	output logic creg_write_en,
	output logic [$clog2(dcache_pkg::NUM_CREGS) - 1:0] creg_index,
	output dcache_pkg::scalar_t creg_write_val,
	output logic dd_valid,
	output dcache_pkg::data_stage_t dd
);

	localparam int WORDS = dcache_pkg::CACHE_LINE_WORDS;

	logic squash;
	logic live;
	logic is_creg;
	logic [WORDS - 1:0] word_mask;
	logic [3:0] byte_mask;
	dcache_pkg::scalar_t store_scalar;

	assign squash = rollback_en && rollback_thread_idx == ts.req.thread_idx;
	assign live = ts_valid && !squash;
	assign is_creg = ts.req.op == dcache_pkg::MEM_CONTROL_REG;
	assign store_scalar = ts.req.store_value[0];

	assign ram_line_idx = ts.line_idx[LINE_IDX_BITS - 1:0];
	assign ram_read_en = live && ts.req.is_load && !is_creg;
	assign ram_write_en = live && !ts.req.is_load && !is_creg;

	assign creg_read_en = live && ts.req.is_load && is_creg;
	assign creg_write_en = live && !ts.req.is_load && is_creg;
	assign creg_index = ts.req.addr[$clog2(dcache_pkg::NUM_CREGS) - 1:0];
	assign creg_write_val = store_scalar;

	// Word select, block lanes come in reversed
	always_comb
	begin
		word_mask = '0;
		if (ts.req.op == dcache_pkg::MEM_BLOCK)
		begin
			for (int w = 0; w < WORDS; w++)
				word_mask[w] = ts.req.mask[WORDS - 1 - w];
		end
		else
			word_mask[ts.word_offset] = 1'b1;
	end

	// Bytes within the word plus the replicated store line
	always_comb
	begin
		byte_mask = 4'b1111;
		ram_write_data = {WORDS{dcache_pkg::byte_swap(store_scalar)}};
		case (ts.req.op)
			dcache_pkg::MEM_B, dcache_pkg::MEM_BX:
			begin
				byte_mask = 4'b0001 << ts.req.addr[1:0];
				ram_write_data = {dcache_pkg::CACHE_LINE_BYTES{store_scalar[7:0]}};
			end

			dcache_pkg::MEM_S, dcache_pkg::MEM_SX:
			begin
				byte_mask = ts.req.addr[1] ? 4'b1100 : 4'b0011;
				ram_write_data = {(WORDS * 2){store_scalar[7:0], store_scalar[15:8]}};
			end

			dcache_pkg::MEM_BLOCK:
			begin
				for (int w = 0; w < WORDS; w++)
				begin
					ram_write_data[w * 32 +: 32] =
						dcache_pkg::byte_swap(ts.req.store_value[WORDS - 1 - w]);
				end
			end

			default:
			begin
				byte_mask = 4'b1111;
			end
		endcase
	end

	// Mask bit b covers line byte b
	always_comb
	begin
		for (int b = 0; b < dcache_pkg::CACHE_LINE_BYTES; b++)
			ram_write_mask[b] = word_mask[b / 4] & byte_mask[b % 4];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			dd_valid <= 1'b0;
		else
			dd_valid <= live;
	end

	always_ff @(posedge clk)
	begin
		dd.op <= ts.req.op;
		dd.is_load <= ts.req.is_load;
		dd.thread_idx <= ts.req.thread_idx;
		dd.word_offset <= ts.word_offset;
		dd.byte_offset <= ts.req.addr[1:0];
	end

endmodule

`default_nettype wire

//--- design/cache_data_ram.sv
//**************************************************************************
// Line-wide data memory
// Byte-enable writes, full line read registered one cycle later
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module cache_data_ram
#(
	parameter int NUM_LINES = 4
)
(
	input wire logic clk,
	input wire logic [$clog2(NUM_LINES) - 1:0] line_idx,
	input wire logic read_en,
	input wire logic write_en,
	input wire logic [dcache_pkg::CACHE_LINE_BYTES * 8 - 1:0] write_data,
	input wire logic [dcache_pkg::CACHE_LINE_BYTES - 1:0] write_mask,
	output logic [dcache_pkg::CACHE_LINE_BYTES * 8 - 1:0] read_data
);

	logic [dcache_pkg::CACHE_LINE_BYTES * 8 - 1:0] lines [NUM_LINES];

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			for (int b = 0; b < dcache_pkg::CACHE_LINE_BYTES; b++)
			begin
				if (write_mask[b])
					lines[line_idx][b * 8 +: 8] <= write_data[b * 8 +: 8];
			end
		end

		// Read returns the old line on a same-cycle write
		if (read_en)
			read_data <= lines[line_idx];
	end

endmodule

`default_nettype wire

//--- design/control_registers.sv
//**************************************************************************
// Control register bank
// Small set of 32-bit registers, cleared on reset, registered read
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module control_registers
(
	input wire logic clk,
	input wire logic reset,
	input wire logic read_en,
	input wire logic write_en,
	input wire logic [$clog2(dcache_pkg::NUM_CREGS) - 1:0] index,
	input wire dcache_pkg::scalar_t write_val,
	output dcache_pkg::scalar_t read_val
);

	dcache_pkg::scalar_t regs [dcache_pkg::NUM_CREGS];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < dcache_pkg::NUM_CREGS; i++)
				regs[i] <= '0;
			read_val <= '0;
		end
		else
		begin
			if (write_en)
				regs[index] <= write_val;
			if (read_en)
				read_val <= regs[index];
		end
	end

endmodule

`default_nettype wire

//--- design/dcache_writeback.sv
//**************************************************************************
// Data cache writeback stage
// Picks load data from the line or control registers and extends it
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_writeback
(
	input wire logic clk,
	input wire logic reset,
	input wire logic dd_valid,
	input wire dcache_pkg::data_stage_t dd,
	input wire logic [dcache_pkg::CACHE_LINE_BYTES * 8 - 1:0] ram_read_data,
	input wire dcache_pkg::scalar_t creg_read_data,
	output logic result_valid,
	output dcache_pkg::mem_result_t result
);

	localparam int WORDS = dcache_pkg::CACHE_LINE_WORDS;

	dcache_pkg::scalar_t load_word;
	logic [7:0] load_byte;
	logic [15:0] load_half;
	dcache_pkg::vector_t load_value;

	// Word back in register order, byte 0 is the MSB
	assign load_word = dcache_pkg::byte_swap(ram_read_data[dd.word_offset * 32 +: 32]);
	assign load_byte = load_word[31 - dd.byte_offset * 8 -: 8];
	assign load_half = dd.byte_offset[1] ? load_word[15:0] : load_word[31:16];

	always_comb
	begin
		load_value = '0;
		case (dd.op)
			dcache_pkg::MEM_B:
				load_value[0] = {24'd0, load_byte};
			dcache_pkg::MEM_BX:
				load_value[0] = {{24{load_byte[7]}}, load_byte};
			dcache_pkg::MEM_S:
				load_value[0] = {16'd0, load_half};
			dcache_pkg::MEM_SX:
				load_value[0] = {{16{load_half[15]}}, load_half};
			dcache_pkg::MEM_BLOCK:
			begin
				for (int k = 0; k < WORDS; k++)
				begin
					load_value[k] =
						dcache_pkg::byte_swap(ram_read_data[(WORDS - 1 - k) * 32 +: 32]);
				end
			end
			dcache_pkg::MEM_CONTROL_REG:
				load_value[0] = creg_read_data;
			default:
				load_value[0] = load_word;
		endcase
	end

	// Stores retire silently
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= dd_valid && dd.is_load;
	end

	always_ff @(posedge clk)
	begin
		result.thread_idx <= dd.thread_idx;
		result.is_vector <= dd.op == dcache_pkg::MEM_BLOCK;
		result.value <= load_value;
	end

endmodule

`default_nettype wire

//--- design/dcache_pipeline.sv
//**************************************************************************
// Data cache pipeline top
// Tag, data and writeback stages around the line memory and control regs
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_pipeline
#(
	parameter int NUM_LINES = 4
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic req_valid,
	input wire dcache_pkg::mem_request_t req,
	input wire logic rollback_en,
	input wire logic [dcache_pkg::THREAD_BITS - 1:0] rollback_thread_idx,
	output logic result_valid,
	output dcache_pkg::mem_result_t result
);

	localparam int LINE_IDX_BITS = $clog2(NUM_LINES);
	localparam int LINE_BITS = dcache_pkg::CACHE_LINE_BYTES * 8;

	logic ts_valid;
	dcache_pkg::tag_stage_t ts;
	logic dd_valid;
	dcache_pkg::data_stage_t dd;

	logic [LINE_IDX_BITS - 1:0] ram_line_idx;
	logic ram_read_en;
	logic ram_write_en;
	logic [LINE_BITS - 1:0] ram_write_data;
	logic [dcache_pkg::CACHE_LINE_BYTES - 1:0] ram_write_mask;
	logic [LINE_BITS - 1:0] ram_read_data;

	logic creg_read_en;
	logic creg_write_en;
	logic [$clog2(dcache_pkg::NUM_CREGS) - 1:0] creg_index;
	dcache_pkg::scalar_t creg_write_val;
	dcache_pkg::scalar_t creg_read_data;

	dcache_tag_stage u_tag_stage (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.ts_valid(ts_valid), .ts(ts));

	dcache_data_stage #(.LINE_IDX_BITS(LINE_IDX_BITS)) u_data_stage (
		.clk(clk), .reset(reset), .ts_valid(ts_valid), .ts(ts),
		.rollback_en(rollback_en), .rollback_thread_idx(rollback_thread_idx),
		.ram_line_idx(ram_line_idx), .ram_read_en(ram_read_en),
		.ram_write_en(ram_write_en), .ram_write_data(ram_write_data),
		.ram_write_mask(ram_write_mask), .creg_read_en(creg_read_en),
		.creg_write_en(creg_write_en), .creg_index(creg_index),
		.creg_write_val(creg_write_val), .dd_valid(dd_valid), .dd(dd));

	cache_data_ram #(.NUM_LINES(NUM_LINES)) u_data_ram (
		.clk(clk), .line_idx(ram_line_idx), .read_en(ram_read_en),
		.write_en(ram_write_en), .write_data(ram_write_data),
		.write_mask(ram_write_mask), .read_data(ram_read_data));

	control_registers u_cregs (
		.clk(clk), .reset(reset), .read_en(creg_read_en),
		.write_en(creg_write_en), .index(creg_index),
		.write_val(creg_write_val), .read_val(creg_read_data));

	dcache_writeback u_writeback (
		.clk(clk), .reset(reset), .dd_valid(dd_valid), .dd(dd),
		.ram_read_data(ram_read_data), .creg_read_data(creg_read_data),
		.result_valid(result_valid), .result(result));

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
//**************************************************************************
// Testbench clock and reset
// 20 ns clock, reset held high for the first two rising edges
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/dcache_pipeline_tb.sv
//**************************************************************************
// Data cache pipeline testbench
// Replays requests from a pattern file against byte-level memory and
// control register models and checks every load result and its timing
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_pipeline_tb;

	localparam int NUM_LINES = 4;
	localparam int MODEL_BYTES = NUM_LINES * dcache_pkg::CACHE_LINE_BYTES;
	localparam int LANES = dcache_pkg::VECTOR_LANES;
	localparam int TB_WORDS = dcache_pkg::CACHE_LINE_WORDS;

	typedef struct packed
	{
		dcache_pkg::mem_op_t op;
		logic is_load;
		logic [dcache_pkg::THREAD_BITS - 1:0] thread_idx;
		dcache_pkg::scalar_t addr;
		logic [LANES - 1:0] mask;
		dcache_pkg::scalar_t value;
		logic [1:0] rollback;
		dcache_pkg::scalar_t expected;
	} pattern_t;

	typedef struct packed
	{
		logic [31:0] due_cycle;
		logic [31:0] pattern_idx;
		logic [dcache_pkg::THREAD_BITS - 1:0] thread_idx;
		logic is_vector;
		dcache_pkg::vector_t value;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	dcache_pkg::mem_request_t req;
	logic rollback_en;
	logic [dcache_pkg::THREAD_BITS - 1:0] rollback_thread_idx;
	logic result_valid;
	dcache_pkg::mem_result_t result;

	pattern_t patterns[$];
	expect_t expected_q[$];
	logic [7:0] mem_model [MODEL_BYTES];
	dcache_pkg::scalar_t creg_model [dcache_pkg::NUM_CREGS];
	logic [31:0] lfsr_state;
	int cycle = 0;
	int mismatch_count = 0;
	int failure_count = 0;
	logic patterns_loaded = 1'b0;

	clock_gen u_clock_gen (.clk(clk), .reset(reset));

	dcache_pipeline #(.NUM_LINES(NUM_LINES)) u_dut (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.rollback_en(rollback_en), .rollback_thread_idx(rollback_thread_idx),
		.result_valid(result_valid), .result(result));

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_vector(output dcache_pkg::vector_t v);
		for (int k = 0; k < LANES; k++)
		begin
			for (int b = 0; b < 32; b++)
			begin
				lfsr_state = lfsr_next(lfsr_state);
				v[k][b] = lfsr_state[0];
			end
		end
	endtask

	task automatic decode_op(input logic [63:0] name, output dcache_pkg::mem_op_t op,
		output logic ok);
		ok = 1'b1;
		op = dcache_pkg::MEM_L;
		case (name)
			"B": op = dcache_pkg::MEM_B;
			"BX": op = dcache_pkg::MEM_BX;
			"S": op = dcache_pkg::MEM_S;
			"SX": op = dcache_pkg::MEM_SX;
			"L": op = dcache_pkg::MEM_L;
			"BLOCK": op = dcache_pkg::MEM_BLOCK;
			"CREG": op = dcache_pkg::MEM_CONTROL_REG;
			default: ok = 1'b0;
		endcase
	endtask

	task automatic load_patterns;
		int fd;
		int fields;
		logic [1023:0] line;
		logic [63:0] first;
		logic [63:0] op_name;
		logic [31:0] load_flag, thread, addr, mask, value, rollback, expected;
		pattern_t p;
		logic ok;
		fd = $fopen("verif/dcache_patterns.txt", "r");
		if (fd == 0)
		begin
			failure_count++;
			$display("Cannot open the pattern file verif/dcache_patterns.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = '0;
				first = '0;
				if ($fgets(line, fd) != 0 && $sscanf(line, "%s", first) == 1 && first != "#")
				begin
					fields = $sscanf(line, "%s %d %d %h %h %h %d %h", op_name, load_flag,
						thread, addr, mask, value, rollback, expected);
					decode_op(op_name, p.op, ok);
					if (fields != 8 || !ok)
					begin
						failure_count++;
						$display("Malformed pattern line after pattern %0d", patterns.size());
					end
					else
					begin
						p.is_load = load_flag[0];
						p.thread_idx = thread[dcache_pkg::THREAD_BITS - 1:0];
						p.addr = addr;
						p.mask = mask[LANES - 1:0];
						p.value = value;
						p.rollback = rollback[1:0];
						p.expected = expected;
						patterns.push_back(p);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Big-endian word with the lowest address as its MSB
	function automatic dcache_pkg::scalar_t word_at(input int a);
		word_at = {mem_model[a], mem_model[a + 1], mem_model[a + 2], mem_model[a + 3]};
	endfunction

	task automatic model_store(input pattern_t p, input dcache_pkg::vector_t v);
		int base;
		base = p.addr[7:0];
		case (p.op)
			dcache_pkg::MEM_B, dcache_pkg::MEM_BX:
				mem_model[base] = p.value[7:0];
			dcache_pkg::MEM_S, dcache_pkg::MEM_SX:
			begin
				base = base & ~1;
				mem_model[base] = p.value[15:8];
				mem_model[base + 1] = p.value[7:0];
			end
			dcache_pkg::MEM_L:
			begin
				base = base & ~3;
				for (int i = 0; i < 4; i++)
					mem_model[base + i] = p.value[31 - 8 * i -: 8];
			end
			dcache_pkg::MEM_BLOCK:
			begin
				// Lane k lands in word 15 - k of the line
				base = base & ~63;
				for (int k = 0; k < LANES; k++)
				begin
					for (int i = 0; i < 4; i++)
					begin
						if (p.mask[k])
							mem_model[base + 4 * (TB_WORDS - 1 - k) + i] = v[k][31 - 8 * i -: 8];
					end
				end
			end
			default:
				creg_model[p.addr[2:0]] = p.value;
		endcase
	endtask

	function automatic dcache_pkg::vector_t model_load(input pattern_t p);
		int base;
		logic [7:0] b;
		logic [15:0] h;
		dcache_pkg::vector_t v;
		v = '0;
		base = p.addr[7:0];
		b = mem_model[base];
		h = {mem_model[base & ~1], mem_model[(base & ~1) + 1]};
		case (p.op)
			dcache_pkg::MEM_B: v[0] = {24'd0, b};
			dcache_pkg::MEM_BX: v[0] = {{24{b[7]}}, b};
			dcache_pkg::MEM_S: v[0] = {16'd0, h};
			dcache_pkg::MEM_SX: v[0] = {{16{h[15]}}, h};
			dcache_pkg::MEM_L: v[0] = word_at(base & ~3);
			dcache_pkg::MEM_BLOCK:
			begin
				for (int k = 0; k < LANES; k++)
					v[k] = word_at((base & ~63) + 4 * (TB_WORDS - 1 - k));
			end
			default: v[0] = creg_model[p.addr[2:0]];
		endcase
		return v;
	endfunction

	task automatic drive_rollback(input int idx);
		rollback_en = 1'b0;
		rollback_thread_idx = '0;
		if (idx >= 0 && idx < patterns.size() && patterns[idx].rollback != 2'd0)
		begin
			rollback_en = 1'b1;
			rollback_thread_idx = patterns[idx].thread_idx;
			// Value 2 aims at the next thread instead
			if (patterns[idx].rollback == 2'd2)
				rollback_thread_idx = patterns[idx].thread_idx + 1'b1;
		end
	endtask

	task automatic drive_pattern(input int idx);
		pattern_t p;
		dcache_pkg::vector_t store_vec;
		dcache_pkg::vector_t model_val;
		expect_t e;
		logic squashed;
		p = patterns[idx];
		store_vec = '0;
		if (p.op == dcache_pkg::MEM_BLOCK && !p.is_load)
			random_vector(store_vec);
		else
			store_vec[0] = p.value;
		req_valid = 1'b1;
		req.op = p.op;
		req.is_load = p.is_load;
		req.thread_idx = p.thread_idx;
		req.addr = p.addr;
		req.mask = p.mask;
		req.store_value = store_vec;
		squashed = p.rollback == 2'd1;
		if (!p.is_load && !squashed)
			model_store(p, store_vec);
		else if (p.is_load && !squashed)
		begin
			model_val = model_load(p);
			if (p.op != dcache_pkg::MEM_BLOCK && model_val[0] !== p.expected)
			begin
				failure_count++;
				$display("Pattern %0d expects %h but the models give %h", idx, p.expected,
					model_val[0]);
			end
			e.due_cycle = cycle + 3;
			e.pattern_idx = idx;
			e.thread_idx = p.thread_idx;
			e.is_vector = p.op == dcache_pkg::MEM_BLOCK;
			e.value = model_val;
			if (!e.is_vector)
				e.value[0] = p.expected;
			expected_q.push_back(e);
		end
	endtask

	task automatic check_scalar(input string name, input dcache_pkg::scalar_t got,
		input dcache_pkg::scalar_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_vector(input string name, input dcache_pkg::vector_t got,
		input dcache_pkg::vector_t exp);
		for (int k = 0; k < LANES; k++)
		begin
			if (got[k] !== exp[k])
			begin
				mismatch_count++;
				$display("MISMATCH at %0t: %s[%0d] got %h expected %h", $time, name, k,
					got[k], exp[k]);
			end
		end
	endtask

	task automatic check_thread(input string name,
		input logic [dcache_pkg::THREAD_BITS - 1:0] got,
		input logic [dcache_pkg::THREAD_BITS - 1:0] exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_output;
		expect_t e;
		if (result_valid === 1'b1)
		begin
			if (expected_q.size() == 0)
			begin
				failure_count++;
				$display("Unexpected result_valid at %0t with no load outstanding", $time);
			end
			else
			begin
				e = expected_q.pop_front();
				if (e.due_cycle != cycle)
				begin
					failure_count++;
					$display("Result of pattern %0d came in cycle %0d instead of cycle %0d",
						e.pattern_idx, cycle, e.due_cycle);
				end
				check_thread("result.thread_idx", result.thread_idx, e.thread_idx);
				check_flag("result.is_vector", result.is_vector, e.is_vector);
				if (e.is_vector)
					check_vector("result.value", result.value, e.value);
				else
					check_scalar("result.value[0]", result.value[0], e.value[0]);
			end
		end
		else if (expected_q.size() != 0 && expected_q[0].due_cycle <= cycle)
		begin
			e = expected_q.pop_front();
			failure_count++;
			$display("No result for pattern %0d, result_valid stayed low in cycle %0d",
				e.pattern_idx, cycle);
		end
	endtask

	// Results are sampled 1 ns after each rising edge
	always @(posedge clk)
	begin
		cycle++;
		#1;
		check_output;
	end

	initial
	begin
		req_valid = 1'b0;
		req = '0;
		rollback_en = 1'b0;
		rollback_thread_idx = '0;
		lfsr_state = 32'hba27_fde9;
		for (int i = 0; i < dcache_pkg::NUM_CREGS; i++)
			creg_model[i] = '0;
		load_patterns;
		patterns_loaded = 1'b1;
		@(negedge reset);
		// Rollback for a request goes out one cycle after it
		for (int i = 0; i <= patterns.size() + 1; i++)
		begin
			@(posedge clk);
			#2;
			drive_rollback(i - 1);
			if (i < patterns.size())
				drive_pattern(i);
			else
				req_valid = 1'b0;
		end
		while (expected_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("Checks done with %0d mismatches and %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		wait (patterns_loaded === 1'b1);
		#((patterns.size() + 10) * 20);
		$display("Timeout after %0d patterns, the pipeline did not drain", patterns.size());
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/dcache_patterns.txt
# op load thread addr mask value rollback expected, with addr mask value expected in hex
# rollback 0 is none, 1 squashes the request's own thread, 2 targets the next thread
BLOCK 0 0 00000000 ffff 00000000 0 00000000
BLOCK 0 1 00000040 ffff 00000000 0 00000000
BLOCK 0 2 00000080 ffff 00000000 0 00000000
BLOCK 0 3 000000c0 ffff 00000000 0 00000000
L     0 0 00000040 0000 8badf00d 0 00000000
L     1 0 00000040 0000 00000000 0 8badf00d
B     1 1 00000040 0000 00000000 0 0000008b
BX    1 1 00000040 0000 00000000 0 ffffff8b
B     1 2 00000043 0000 00000000 0 0000000d
S     1 3 00000042 0000 00000000 0 0000f00d
SX    1 0 00000042 0000 00000000 0 fffff00d
S     1 0 00000040 0000 00000000 0 00008bad
SX    1 1 00000040 0000 00000000 0 ffff8bad
B     0 2 00000045 0000 000000c3 0 00000000
S     0 2 00000046 0000 00001234 0 00000000
B     0 2 00000044 0000 0000007e 0 00000000
L     1 3 00000044 0000 00000000 0 7ec31234
BX    1 3 00000045 0000 00000000 0 ffffffc3
SX    1 1 00000046 0000 00000000 0 00001234
BLOCK 0 1 00000080 a5c3 00000000 0 00000000
BLOCK 1 1 00000080 0000 00000000 0 00000000
BLOCK 1 0 00000040 0000 00000000 0 00000000
CREG  1 0 00000005 0000 00000000 0 00000000
CREG  0 0 00000003 0000 cafe0003 0 00000000
CREG  0 1 00000007 0000 12345678 0 00000000
CREG  1 2 00000003 0000 00000000 0 cafe0003
CREG  1 3 00000007 0000 00000000 0 12345678
BLOCK 1 0 00000000 0000 00000000 0 00000000
L     0 2 00000048 0000 deadbeef 0 00000000
L     0 1 00000048 0000 11111111 1 00000000
L     1 2 00000048 0000 00000000 0 deadbeef
L     1 3 00000048 0000 00000000 1 00000000
L     0 0 0000004c 0000 5a5a5a5a 2 00000000
L     1 1 0000004c 0000 00000000 2 5a5a5a5a
CREG  0 3 00000001 0000 0badc0de 1 00000000
CREG  1 3 00000001 0000 00000000 0 00000000
BLOCK 0 2 000000c0 ffff 00000000 1 00000000
BLOCK 1 2 000000c0 0000 00000000 0 00000000

//--- files.f
design/dcache_pkg.sv
design/dcache_tag_stage.sv
design/dcache_data_stage.sv
design/cache_data_ram.sv
design/control_registers.sv
design/dcache_writeback.sv
design/dcache_pipeline.sv
verif/clock_gen.sv
verif/dcache_pipeline_tb.sv

//--- Bender.yml
package:
  name: dcache_pipeline

sources:
  - design/dcache_pkg.sv
  - design/dcache_tag_stage.sv
  - design/dcache_data_stage.sv
  - design/cache_data_ram.sv
  - design/control_registers.sv
  - design/dcache_writeback.sv
  - design/dcache_pipeline.sv
  - target: test
    files:
      - verif/clock_gen.sv
      - verif/dcache_pipeline_tb.sv
